// File: cpu_cfg_pkg.sv
package cpu_cfg_pkg;

    localparam int ISSUE_WIDTH = 2;   // Issued and retired per cycle
    localparam int IB_DEPTH    = 8;   // Also the sender's initial credits
    localparam int NUM_REGS    = 32;
    localparam int RF_RD_PORTS = 2 * ISSUE_WIDTH;

    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    // Credits handed back per cycle, 0 to 2
    typedef logic [1:0] credit_t;

    typedef logic [2:0] ib_ptr_t;
    typedef logic [3:0] ib_count_t;

endpackage

// File: isa_pkg.sv
package isa_pkg;

    // LoongArch field positions
    localparam int RD_LSB    = 0;
    localparam int RJ_LSB    = 5;
    localparam int RK_LSB    = 10;
    localparam int IMM12_LSB = 10;
    localparam int OPC17_LSB = 15;
    localparam int OPC10_LSB = 22;

    // 3R forms, opcode in bits 31:15
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002A;
    localparam logic [16:0] OP_XOR   = 17'h0002B;

    // 2RI12 form, opcode in bits 31:22
    localparam logic [9:0] OP_ADDI_W = 10'h00A;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NONE    // Undecoded, retires without a write
    } alu_op_e;

endpackage

// File: issue_if.sv
`timescale 1ns/1ns

// Issue to execute, one entry per slot; execute never stalls
interface issue_if;

    logic                   valid     [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::pc_t       pc        [cpu_cfg_pkg::ISSUE_WIDTH];
    isa_pkg::alu_op_e       alu_op    [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::reg_addr_t rd        [cpu_cfg_pkg::ISSUE_WIDTH];
    logic                   we        [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::word_t     operand_a [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::word_t     operand_b [cpu_cfg_pkg::ISSUE_WIDTH];

    modport issue (
        output valid, pc, alu_op, rd, we, operand_a, operand_b
    );

    modport exec (
        input valid, pc, alu_op, rd, we, operand_a, operand_b
    );

endinterface

// File: instr_buffer.sv
`timescale 1ns/1ns

module instr_buffer (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  logic                   push_i,
    input  cpu_cfg_pkg::pc_t       push_pc_i,
    input  cpu_cfg_pkg::instr_t    push_instr_i,

    output cpu_cfg_pkg::pc_t       head_pc_o    [cpu_cfg_pkg::ISSUE_WIDTH],
    output cpu_cfg_pkg::instr_t    head_instr_o [cpu_cfg_pkg::ISSUE_WIDTH],
    output cpu_cfg_pkg::ib_count_t head_count_o,
    input  cpu_cfg_pkg::credit_t   pop_count_i,

    output cpu_cfg_pkg::credit_t   credit_return_o
);

    cpu_cfg_pkg::pc_t       mem_pc    [cpu_cfg_pkg::IB_DEPTH];
    cpu_cfg_pkg::instr_t    mem_instr [cpu_cfg_pkg::IB_DEPTH];
    cpu_cfg_pkg::ib_ptr_t   wr_ptr_q;
    cpu_cfg_pkg::ib_ptr_t   rd_ptr_q;
    cpu_cfg_pkg::ib_count_t count_q;
    cpu_cfg_pkg::credit_t   credit_q;

    always_ff @(posedge clk) begin
        if (push_i) begin   // Sender holds a credit, so never full here
            mem_pc[wr_ptr_q]    <= push_pc_i;
            mem_instr[wr_ptr_q] <= push_instr_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + cpu_cfg_pkg::ib_ptr_t'(push_i);
            rd_ptr_q <= rd_ptr_q + cpu_cfg_pkg::ib_ptr_t'(pop_count_i);
            count_q  <= count_q + cpu_cfg_pkg::ib_count_t'(push_i)
                        - cpu_cfg_pkg::ib_count_t'(pop_count_i);
            credit_q <= pop_count_i;   // Popped entries go back next cycle
        end
    end

    // Two oldest entries, pointer wraps at the depth
    always_comb begin
        for (int k = 0; k < cpu_cfg_pkg::ISSUE_WIDTH; k++) begin
            head_pc_o[k]    = mem_pc[cpu_cfg_pkg::ib_ptr_t'(rd_ptr_q + k)];
            head_instr_o[k] = mem_instr[cpu_cfg_pkg::ib_ptr_t'(rd_ptr_q + k)];
        end
    end

    assign head_count_o    = count_q;
    assign credit_return_o = credit_q;

endmodule

// File: issue_stage.sv
`timescale 1ns/1ns

module issue_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  cpu_cfg_pkg::pc_t       head_pc_i    [cpu_cfg_pkg::ISSUE_WIDTH],
    input  cpu_cfg_pkg::instr_t    head_instr_i [cpu_cfg_pkg::ISSUE_WIDTH],
    input  cpu_cfg_pkg::ib_count_t head_count_i,
    output cpu_cfg_pkg::credit_t   pop_count_o,

    output cpu_cfg_pkg::reg_addr_t rf_raddr_o [cpu_cfg_pkg::RF_RD_PORTS],
    input  cpu_cfg_pkg::word_t     rf_rdata_i [cpu_cfg_pkg::RF_RD_PORTS],

    issue_if.issue                 iss
);

    isa_pkg::alu_op_e       op      [cpu_cfg_pkg::ISSUE_WIDTH];
    logic                   use_rj  [cpu_cfg_pkg::ISSUE_WIDTH];
    logic                   use_rk  [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::reg_addr_t rd      [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::reg_addr_t rj      [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::reg_addr_t rk      [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::word_t     imm     [cpu_cfg_pkg::ISSUE_WIDTH];
    logic                   raw_ex  [cpu_cfg_pkg::ISSUE_WIDTH];
    logic                   go      [cpu_cfg_pkg::ISSUE_WIDTH];
    logic                   ex_wr_q [cpu_cfg_pkg::ISSUE_WIDTH];   // Mirror of execute register
    cpu_cfg_pkg::reg_addr_t ex_rd_q [cpu_cfg_pkg::ISSUE_WIDTH];

    // True if a real source of the slot is r, r0 never counts
    function automatic logic reads_reg(
        input logic                   src_j,
        input cpu_cfg_pkg::reg_addr_t addr_j,
        input logic                   src_k,
        input cpu_cfg_pkg::reg_addr_t addr_k,
        input cpu_cfg_pkg::reg_addr_t r
    );
        return (r != '0) && ((src_j && addr_j == r) || (src_k && addr_k == r));
    endfunction

    always_comb begin
        for (int i = 0; i < cpu_cfg_pkg::ISSUE_WIDTH; i++) begin
            rd[i]     = head_instr_i[i][isa_pkg::RD_LSB +: 5];
            rj[i]     = head_instr_i[i][isa_pkg::RJ_LSB +: 5];
            rk[i]     = head_instr_i[i][isa_pkg::RK_LSB +: 5];
            imm[i]    = cpu_cfg_pkg::word_t'($signed(head_instr_i[i][isa_pkg::IMM12_LSB +: 12]));
            op[i]     = isa_pkg::ALU_NONE;
            use_rk[i] = 1'b1;
            case (head_instr_i[i][isa_pkg::OPC17_LSB +: 17])
                isa_pkg::OP_ADD_W: op[i] = isa_pkg::ALU_ADD;
                isa_pkg::OP_SUB_W: op[i] = isa_pkg::ALU_SUB;
                isa_pkg::OP_AND:   op[i] = isa_pkg::ALU_AND;
                isa_pkg::OP_OR:    op[i] = isa_pkg::ALU_OR;
                isa_pkg::OP_XOR:   op[i] = isa_pkg::ALU_XOR;
                default:           use_rk[i] = 1'b0;
            endcase
            if (head_instr_i[i][isa_pkg::OPC10_LSB +: 10] == isa_pkg::OP_ADDI_W) begin
                op[i] = isa_pkg::ALU_ADD;
            end
            use_rj[i] = (op[i] != isa_pkg::ALU_NONE);
        end
    end

    // Stall on anything still in execute, no forwarding
    always_comb begin
        for (int i = 0; i < cpu_cfg_pkg::ISSUE_WIDTH; i++) begin
            raw_ex[i] = 1'b0;
            for (int k = 0; k < cpu_cfg_pkg::ISSUE_WIDTH; k++) begin
                if (ex_wr_q[k] && reads_reg(use_rj[i], rj[i], use_rk[i], rk[i], ex_rd_q[k])) begin
                    raw_ex[i] = 1'b1;
                end
            end
        end
        go[0] = (head_count_i != '0) && !raw_ex[0];
        go[1] = go[0] && (head_count_i > cpu_cfg_pkg::ib_count_t'(1)) && !raw_ex[1]
                && !(use_rj[0] && reads_reg(use_rj[1], rj[1], use_rk[1], rk[1], rd[0]));
    end

    always_comb begin
        for (int i = 0; i < cpu_cfg_pkg::ISSUE_WIDTH; i++) begin
            rf_raddr_o[2*i]   = rj[i];
            rf_raddr_o[2*i+1] = rk[i];
            iss.valid[i]      = go[i];
            iss.pc[i]         = head_pc_i[i];
            iss.alu_op[i]     = op[i];
            iss.rd[i]         = rd[i];
            iss.we[i]         = use_rj[i];
            iss.operand_a[i]  = rf_rdata_i[2*i];
            iss.operand_b[i]  = use_rk[i] ? rf_rdata_i[2*i+1] : imm[i];
        end
    end

    assign pop_count_o = cpu_cfg_pkg::credit_t'(go[0]) + cpu_cfg_pkg::credit_t'(go[1]);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int k = 0; k < cpu_cfg_pkg::ISSUE_WIDTH; k++) begin
                ex_wr_q[k] <= 1'b0;
            end
        end else begin
            for (int k = 0; k < cpu_cfg_pkg::ISSUE_WIDTH; k++) begin
                ex_wr_q[k] <= go[k] && use_rj[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < cpu_cfg_pkg::ISSUE_WIDTH; k++) begin
            ex_rd_q[k] <= rd[k];
        end
    end

endmodule

// File: regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  cpu_cfg_pkg::reg_addr_t raddr_i [cpu_cfg_pkg::RF_RD_PORTS],
    output cpu_cfg_pkg::word_t     rdata_o [cpu_cfg_pkg::RF_RD_PORTS],

    input  logic                   we_i    [cpu_cfg_pkg::ISSUE_WIDTH],
    input  cpu_cfg_pkg::reg_addr_t waddr_i [cpu_cfg_pkg::ISSUE_WIDTH],
    input  cpu_cfg_pkg::word_t     wdata_i [cpu_cfg_pkg::ISSUE_WIDTH]
);

    cpu_cfg_pkg::word_t regs [cpu_cfg_pkg::NUM_REGS];

    // Later port is the younger instruction, so it wins
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < cpu_cfg_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < cpu_cfg_pkg::ISSUE_WIDTH; w++) begin
                if (we_i[w] && waddr_i[w] != '0) begin
                    regs[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < cpu_cfg_pkg::RF_RD_PORTS; p++) begin
            rdata_o[p] = regs[raddr_i[p]];
            for (int w = 0; w < cpu_cfg_pkg::ISSUE_WIDTH; w++) begin
                if (we_i[w] && waddr_i[w] == raddr_i[p]) begin
                    rdata_o[p] = wdata_i[w];   // Writeback bypass
                end
            end
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end
        end
    end

endmodule

// File: exec_wb.sv
`timescale 1ns/1ns

module exec_wb (
    input  logic                   clk,
    input  logic                   rst_n_i,

    issue_if.exec                  ex,

    output logic                   rf_we_o        [cpu_cfg_pkg::ISSUE_WIDTH],
    output cpu_cfg_pkg::reg_addr_t rf_waddr_o     [cpu_cfg_pkg::ISSUE_WIDTH],
    output cpu_cfg_pkg::word_t     rf_wdata_o     [cpu_cfg_pkg::ISSUE_WIDTH],

    output logic                   commit_valid_o [cpu_cfg_pkg::ISSUE_WIDTH],
    output cpu_cfg_pkg::pc_t       commit_pc_o    [cpu_cfg_pkg::ISSUE_WIDTH],
    output logic                   commit_we_o    [cpu_cfg_pkg::ISSUE_WIDTH],
    output cpu_cfg_pkg::reg_addr_t commit_rd_o    [cpu_cfg_pkg::ISSUE_WIDTH],
    output cpu_cfg_pkg::word_t     commit_wdata_o [cpu_cfg_pkg::ISSUE_WIDTH]
);

    logic                   ex_valid_q [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::pc_t       ex_pc_q    [cpu_cfg_pkg::ISSUE_WIDTH];
    isa_pkg::alu_op_e       ex_op_q    [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::reg_addr_t ex_rd_q    [cpu_cfg_pkg::ISSUE_WIDTH];
    logic                   ex_we_q    [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::word_t     ex_a_q     [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::word_t     ex_b_q     [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::word_t     alu_res    [cpu_cfg_pkg::ISSUE_WIDTH];
    logic                   wb_valid_q [cpu_cfg_pkg::ISSUE_WIDTH];
    logic                   wb_we_q    [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::pc_t       wb_pc_q    [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::reg_addr_t wb_rd_q    [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::word_t     wb_data_q  [cpu_cfg_pkg::ISSUE_WIDTH];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < cpu_cfg_pkg::ISSUE_WIDTH; i++) begin
                ex_valid_q[i] <= 1'b0;
                wb_valid_q[i] <= 1'b0;
                wb_we_q[i]    <= 1'b0;
            end
        end else begin
            for (int i = 0; i < cpu_cfg_pkg::ISSUE_WIDTH; i++) begin
                ex_valid_q[i] <= ex.valid[i];
                wb_valid_q[i] <= ex_valid_q[i];
                wb_we_q[i]    <= ex_valid_q[i] && ex_we_q[i] && ex_rd_q[i] != '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < cpu_cfg_pkg::ISSUE_WIDTH; i++) begin
            ex_pc_q[i]   <= ex.pc[i];
            ex_op_q[i]   <= ex.alu_op[i];
            ex_rd_q[i]   <= ex.rd[i];
            ex_we_q[i]   <= ex.we[i];
            ex_a_q[i]    <= ex.operand_a[i];
            ex_b_q[i]    <= ex.operand_b[i];
            wb_pc_q[i]   <= ex_pc_q[i];
            wb_rd_q[i]   <= ex_rd_q[i];
            wb_data_q[i] <= alu_res[i];
        end
    end

    // Add and subtract wrap at 32 bits
    always_comb begin
        for (int i = 0; i < cpu_cfg_pkg::ISSUE_WIDTH; i++) begin
            case (ex_op_q[i])
                isa_pkg::ALU_ADD: alu_res[i] = ex_a_q[i] + ex_b_q[i];
                isa_pkg::ALU_SUB: alu_res[i] = ex_a_q[i] - ex_b_q[i];
                isa_pkg::ALU_AND: alu_res[i] = ex_a_q[i] & ex_b_q[i];
                isa_pkg::ALU_OR:  alu_res[i] = ex_a_q[i] | ex_b_q[i];
                isa_pkg::ALU_XOR: alu_res[i] = ex_a_q[i] ^ ex_b_q[i];
                default:          alu_res[i] = '0;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < cpu_cfg_pkg::ISSUE_WIDTH; i++) begin
            rf_we_o[i]        = wb_we_q[i];
            rf_waddr_o[i]     = wb_rd_q[i];
            rf_wdata_o[i]     = wb_data_q[i];
            commit_valid_o[i] = wb_valid_q[i];
            commit_pc_o[i]    = wb_pc_q[i];
            commit_we_o[i]    = wb_we_q[i];
            commit_rd_o[i]    = wb_rd_q[i];
            commit_wdata_o[i] = wb_data_q[i];
        end
    end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
    input  logic                   clk,
    input  logic                   rst_n_i,

    input  logic                   instr_valid_i,
    input  cpu_cfg_pkg::pc_t       instr_pc_i,
    input  cpu_cfg_pkg::instr_t    instr_i,
    output cpu_cfg_pkg::credit_t   credit_return_o,

    // Index 0 is the older instruction
    output logic                   commit_valid_o [cpu_cfg_pkg::ISSUE_WIDTH],
    output cpu_cfg_pkg::pc_t       commit_pc_o    [cpu_cfg_pkg::ISSUE_WIDTH],
    output logic                   commit_we_o    [cpu_cfg_pkg::ISSUE_WIDTH],
    output cpu_cfg_pkg::reg_addr_t commit_rd_o    [cpu_cfg_pkg::ISSUE_WIDTH],
    output cpu_cfg_pkg::word_t     commit_wdata_o [cpu_cfg_pkg::ISSUE_WIDTH]
);

    cpu_cfg_pkg::pc_t       ib_head_pc    [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::instr_t    ib_head_instr [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::ib_count_t ib_head_count;
    cpu_cfg_pkg::credit_t   pop_count;
    cpu_cfg_pkg::reg_addr_t rf_raddr [cpu_cfg_pkg::RF_RD_PORTS];
    cpu_cfg_pkg::word_t     rf_rdata [cpu_cfg_pkg::RF_RD_PORTS];
    logic                   rf_we    [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::reg_addr_t rf_waddr [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::word_t     rf_wdata [cpu_cfg_pkg::ISSUE_WIDTH];

    issue_if u_issue_if ();

    instr_buffer u_instr_buffer (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .push_i          (instr_valid_i),
        .push_pc_i       (instr_pc_i),
        .push_instr_i    (instr_i),
        .head_pc_o       (ib_head_pc),
        .head_instr_o    (ib_head_instr),
        .head_count_o    (ib_head_count),
        .pop_count_i     (pop_count),
        .credit_return_o (credit_return_o)
    );

    issue_stage u_issue_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .head_pc_i    (ib_head_pc),
        .head_instr_i (ib_head_instr),
        .head_count_i (ib_head_count),
        .pop_count_o  (pop_count),
        .rf_raddr_o   (rf_raddr),
        .rf_rdata_i   (rf_rdata),
        .iss          (u_issue_if.issue)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata)
    );

    exec_wb u_exec_wb (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ex             (u_issue_if.exec),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_we_o    (commit_we_o),
        .commit_rd_o    (commit_rd_o),
        .commit_wdata_o (commit_wdata_o)
    );

endmodule

// File: tb_cpu_top.sv
`timescale 1ns/1ns

module tb_cpu_top;

    localparam int WAIT_LIMIT = 200;   // Cycles per wait loop

    typedef struct packed {
        cpu_cfg_pkg::pc_t       pc;
        logic                   we;
        cpu_cfg_pkg::reg_addr_t rd;
        cpu_cfg_pkg::word_t     data;
    } commit_t;

    logic                   clk = 1'b0;
    logic                   rst_n_i;
    logic                   instr_valid_i;
    cpu_cfg_pkg::pc_t       instr_pc_i;
    cpu_cfg_pkg::instr_t    instr_i;
    cpu_cfg_pkg::credit_t   credit_return_o;
    logic                   commit_valid_o [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::pc_t       commit_pc_o    [cpu_cfg_pkg::ISSUE_WIDTH];
    logic                   commit_we_o    [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::reg_addr_t commit_rd_o    [cpu_cfg_pkg::ISSUE_WIDTH];
    cpu_cfg_pkg::word_t     commit_wdata_o [cpu_cfg_pkg::ISSUE_WIDTH];

    cpu_cfg_pkg::word_t model_regs [cpu_cfg_pkg::NUM_REGS];
    commit_t            exp_q [$];
    cpu_cfg_pkg::pc_t   next_pc;
    int                 credits;
    int                 pushed;
    int                 returned;
    int                 errors;
    int                 tests_run;
    int                 tests_failed;
    int                 seed;

    cpu_top u_cpu_top (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .instr_valid_i   (instr_valid_i),
        .instr_pc_i      (instr_pc_i),
        .instr_i         (instr_i),
        .credit_return_o (credit_return_o),
        .commit_valid_o  (commit_valid_o),
        .commit_pc_o     (commit_pc_o),
        .commit_we_o     (commit_we_o),
        .commit_rd_o     (commit_rd_o),
        .commit_wdata_o  (commit_wdata_o)
    );

    always #4 clk = ~clk;

    task automatic check_word(input string name, input cpu_cfg_pkg::word_t got,
                              input cpu_cfg_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input string name, input cpu_cfg_pkg::pc_t got,
                            input cpu_cfg_pkg::pc_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input cpu_cfg_pkg::reg_addr_t got,
                             input cpu_cfg_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got r%0d expected r%0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_credit(input string name, input cpu_cfg_pkg::credit_t got,
                                input cpu_cfg_pkg::credit_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic cpu_cfg_pkg::instr_t encode_3r(input logic [16:0] op,
            input cpu_cfg_pkg::reg_addr_t rd, input cpu_cfg_pkg::reg_addr_t rj,
            input cpu_cfg_pkg::reg_addr_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic cpu_cfg_pkg::instr_t encode_addi(input cpu_cfg_pkg::reg_addr_t rd,
            input cpu_cfg_pkg::reg_addr_t rj, input logic [11:0] imm);
        return {isa_pkg::OP_ADDI_W, imm, rj, rd};
    endfunction

    // Sequential execution of one instruction, in push order
    function automatic void model_execute(input cpu_cfg_pkg::pc_t pc,
                                          input cpu_cfg_pkg::instr_t ins);
        cpu_cfg_pkg::word_t a;
        cpu_cfg_pkg::word_t b;
        cpu_cfg_pkg::word_t imm;
        commit_t            e;
        a      = model_regs[ins[9:5]];
        b      = model_regs[ins[14:10]];
        imm    = {{20{ins[21]}}, ins[21:10]};
        e.pc   = pc;
        e.rd   = ins[4:0];
        e.we   = 1'b1;
        e.data = '0;
        case (ins[31:15])
            isa_pkg::OP_ADD_W: e.data = a + b;
            isa_pkg::OP_SUB_W: e.data = a - b;
            isa_pkg::OP_AND:   e.data = a & b;
            isa_pkg::OP_OR:    e.data = a | b;
            isa_pkg::OP_XOR:   e.data = a ^ b;
            default:           e.we = 1'b0;
        endcase
        if (ins[31:22] == isa_pkg::OP_ADDI_W) begin
            e.we   = 1'b1;
            e.data = a + imm;
        end
        if (e.rd == '0) begin
            e.we = 1'b0;   // r0 stays zero
        end
        if (e.we) begin
            model_regs[e.rd] = e.data;
        end
        exp_q.push_back(e);
    endfunction

    // One clock, with credit bookkeeping
    task automatic tick();
        @(posedge clk);
        credits       = credits + int'(credit_return_o);
        returned      = returned + int'(credit_return_o);
        instr_valid_i <= 1'b0;
        if (returned > pushed) begin
            $display("Credits returned (%0d) exceed instructions pushed (%0d) at %0t",
                     returned, pushed, $time);
            errors++;
        end
    endtask

    task automatic send_instr(input cpu_cfg_pkg::instr_t ins);
        int waited;
        waited = 0;
        tick();
        while (credits == 0 && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (credits == 0) begin
            $display("No credit came back within %0d cycles, instruction dropped", WAIT_LIMIT);
            errors++;
        end else begin
            instr_valid_i <= 1'b1;
            instr_pc_i    <= next_pc;
            instr_i       <= ins;
            credits--;
            pushed++;
            model_execute(next_pc, ins);
            next_pc = next_pc + 32'd4;
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out with %0d commits still missing", exp_q.size());
            errors++;
            exp_q.delete();
        end
        tick();
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // Older channel first, so order matches program order
    always @(posedge clk) begin : commit_checker
        commit_t e;
        for (int ch = 0; ch < cpu_cfg_pkg::ISSUE_WIDTH; ch++) begin
            if (rst_n_i && commit_valid_o[ch]) begin
                if (exp_q.size() == 0) begin
                    $display("Commit on channel %0d at %0t with nothing outstanding", ch, $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_pc($sformatf("commit_pc_o[%0d]", ch), commit_pc_o[ch], e.pc);
                    check_bit($sformatf("commit_we_o[%0d]", ch), commit_we_o[ch], e.we);
                    check_reg($sformatf("commit_rd_o[%0d]", ch), commit_rd_o[ch], e.rd);
                    if (e.we) begin
                        check_word($sformatf("commit_wdata_o[%0d]", ch),
                                   commit_wdata_o[ch], e.data);
                    end
                end
            end
        end
    end

    initial begin
        int                     errs_before;
        int                     n;
        int                     kind;
        int                     waited;
        cpu_cfg_pkg::reg_addr_t rd;
        cpu_cfg_pkg::reg_addr_t rj;
        cpu_cfg_pkg::reg_addr_t rk;
        logic [11:0]            imm;
        cpu_cfg_pkg::instr_t    ins;

        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_pc_i    = '0;
        instr_i       = '0;
        next_pc       = 32'h1c00_0000;
        credits       = cpu_cfg_pkg::IB_DEPTH;
        pushed        = 0;
        returned      = 0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        seed          = 83535;
        for (int r = 0; r < cpu_cfg_pkg::NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;

        errs_before = errors;
        for (int c = 0; c < 6; c++) begin
            tick();
            check_credit("credit_return_o", credit_return_o, '0);
            check_bit("commit_valid_o[0]", commit_valid_o[0], 1'b0);
            check_bit("commit_valid_o[1]", commit_valid_o[1], 1'b0);
        end
        close_test("idle after reset", errs_before);

        errs_before = errors;
        send_instr(encode_addi(5'd1, 5'd0, 12'h123));
        send_instr(encode_addi(5'd2, 5'd0, 12'hFFF));   // -1
        send_instr(encode_addi(5'd3, 5'd0, 12'h7FF));
        send_instr(encode_addi(5'd4, 5'd0, 12'h800));   // Most negative
        send_instr(encode_addi(5'd0, 5'd0, 12'h055));
        send_instr(encode_addi(5'd5, 5'd0, 12'h00A));
        drain_pipeline();
        close_test("independent ADDI.W", errs_before);

        errs_before = errors;
        send_instr(encode_addi(5'd11, 5'd0, 12'h035));
        send_instr(encode_addi(5'd12, 5'd11, 12'h0F0));   // Reads partner slot
        send_instr(encode_3r(isa_pkg::OP_ADD_W, 5'd13, 5'd11, 5'd12));
        send_instr(encode_3r(isa_pkg::OP_SUB_W, 5'd14, 5'd13, 5'd12));
        send_instr(encode_3r(isa_pkg::OP_AND, 5'd15, 5'd14, 5'd13));
        send_instr(encode_3r(isa_pkg::OP_OR, 5'd16, 5'd15, 5'd12));
        send_instr(encode_3r(isa_pkg::OP_XOR, 5'd17, 5'd16, 5'd14));
        send_instr(encode_3r(isa_pkg::OP_SUB_W, 5'd11, 5'd0, 5'd17));
        send_instr(encode_3r(isa_pkg::OP_ADD_W, 5'd12, 5'd11, 5'd11));
        send_instr(encode_3r(isa_pkg::OP_XOR, 5'd13, 5'd12, 5'd12));
        drain_pipeline();
        close_test("dependent chains", errs_before);

        errs_before = errors;
        n = 0;
        send_instr(encode_addi(5'd9, 5'd0, 12'h001));
        send_instr(encode_addi(5'd10, 5'd0, 12'h003));
        while (credits > 0 && n < 64) begin
            send_instr(encode_3r(isa_pkg::OP_ADD_W, 5'd9, 5'd9, 5'd10));
            n++;
        end
        if (credits != 0) begin
            $display("Credits never ran out after %0d chained pushes", n);
            errors++;
        end
        drain_pipeline();
        waited = 0;
        while (credits != cpu_cfg_pkg::IB_DEPTH && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (credits != cpu_cfg_pkg::IB_DEPTH) begin
            $display("Only %0d of %0d credits came back after draining",
                     credits, cpu_cfg_pkg::IB_DEPTH);
            errors++;
        end
        close_test("credit flow", errs_before);

        errs_before = errors;
        for (int i = 0; i < 200; i++) begin
            kind = $unsigned($random(seed)) % 7;
            rd   = cpu_cfg_pkg::reg_addr_t'($random(seed) & 7);   // Few regs, more hazards
            rj   = cpu_cfg_pkg::reg_addr_t'($random(seed) & 7);
            rk   = cpu_cfg_pkg::reg_addr_t'($random(seed) & 7);
            imm  = 12'($random(seed));
            case (kind)
                0:       ins = encode_3r(isa_pkg::OP_ADD_W, rd, rj, rk);
                1:       ins = encode_3r(isa_pkg::OP_SUB_W, rd, rj, rk);
                2:       ins = encode_3r(isa_pkg::OP_AND, rd, rj, rk);
                3:       ins = encode_3r(isa_pkg::OP_OR, rd, rj, rk);
                4:       ins = encode_3r(isa_pkg::OP_XOR, rd, rj, rk);
                5:       ins = encode_addi(rd, rj, imm);
                default: ins = cpu_cfg_pkg::instr_t'($random(seed));
            endcase
            send_instr(ins);
        end
        drain_pipeline();
        close_test("random program", errs_before);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: all.f
cpu_cfg_pkg.sv
isa_pkg.sv
issue_if.sv
instr_buffer.sv
issue_stage.sv
regfile.sv
exec_wb.sv
cpu_top.sv
tb_cpu_top.sv

// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing --top-module tb_cpu_top -f all.f -o sim_cpu
./obj_dir/sim_cpu | tee sim.log

# A missing pass line fails the script through set -e
grep -q "All tests passed" sim.log
echo "Simulation finished without errors"
